/* include/controller_defs.svh */
`ifndef CONTROLLER_DEFS_SVH
`define CONTROLLER_DEFS_SVH

// Instruction word width
`define INSTR_W 32

//////////////////////////////////////////////////
// RV32 major opcodes, instruction[6:0]
//////////////////////////////////////////////////
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

//////////////////////////////////////////////////
// Load/store width codes, instruction[14:12]
//////////////////////////////////////////////////
`define F3_BYTE   3'd0
`define F3_HALF   3'd1
`define F3_WORD   3'd2
`define F3_BYTE_U 3'd4  // Loads only
`define F3_HALF_U 3'd5  // Loads only

`endif

/* source/controller_pkg.sv */
package controller_pkg;

    // Decoded instruction class
    typedef enum logic [2:0]
    {
        CLS_RTYPE,
        CLS_ITYPE,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR
    } instr_class_e;

    typedef enum logic [1:0]
    {
        W_NONE,
        W_BYTE,
        W_HALF,
        W_WORD
    } mem_width_e;

    // Next PC source
    typedef enum logic [1:0]
    {
        PC_PLUS4  = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JAL    = 2'd2,
        PC_JALR   = 2'd3
    } pc_sel_e;

    // Register file write-back source
    typedef enum logic [1:0]
    {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // Control word to the datapath, 12 bits
    typedef struct packed
    {
        logic       pc_en;
        pc_sel_e    pc_select;
        logic       alu_src;     // 1 selects the immediate as ALU operand b
        logic       reg_write;
        wb_sel_e    mem_to_reg;
        logic       is_byte;
        logic       is_half;
        logic       is_word;
        logic       mem_read;
        logic       mem_write;
    } ctrl_t;

    // Dispatcher to sequencer command, 7 bits
    typedef struct packed
    {
        logic         go;        // One-cycle start
        instr_class_e cls;
        mem_width_e   width;
        logic         taken;     // Branch comparator at accept
    } seq_cmd_t;

endpackage

/* source/instr_dispatch.sv */
`timescale 1ns/1ps
`include "controller_defs.svh"

module instr_dispatch
    import controller_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [`INSTR_W-1:0] instruction,
    input  logic                comparator,
    input  ctrl_t               alu_ctrl,
    input  ctrl_t               mem_ctrl,
    input  ctrl_t               jump_ctrl,
    input  logic                alu_done,
    input  logic                mem_done,
    input  logic                jump_done,
    input  logic                alu_busy,
    input  logic                mem_busy,
    input  logic                jump_busy,
    output seq_cmd_t            alu_cmd,
    output seq_cmd_t            mem_cmd,
    output seq_cmd_t            jump_cmd,
    output ctrl_t               ctrl,
    output logic                busy,
    output logic                done,
    output logic                illegal
);

    logic [6:0]   opcode;
    logic [2:0]   func3;
    instr_class_e cls;
    mem_width_e   width;
    logic         legal;
    logic         accept;
    logic         any_go;

    assign opcode = instruction[6:0];
    assign func3  = instruction[14:12];

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    always_comb
    begin
        cls   = CLS_RTYPE;
        width = W_NONE;
        legal = 1'b1;
        case (opcode)
            `OP_RTYPE:  cls = CLS_RTYPE;
            `OP_ITYPE:  cls = CLS_ITYPE;
            `OP_BRANCH: cls = CLS_BRANCH;
            `OP_JAL:    cls = CLS_JAL;
            `OP_JALR:   cls = CLS_JALR;
            `OP_LOAD:
            begin
                cls = CLS_LOAD;
                case (func3)
                    `F3_BYTE, `F3_BYTE_U: width = W_BYTE;
                    `F3_HALF, `F3_HALF_U: width = W_HALF;
                    `F3_WORD:             width = W_WORD;
                    default:              legal = 1'b0;
                endcase
            end
            `OP_STORE:
            begin
                cls = CLS_STORE;
                case (func3)    // No unsigned stores
                    `F3_BYTE: width = W_BYTE;
                    `F3_HALF: width = W_HALF;
                    `F3_WORD: width = W_WORD;
                    default:  legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // A start while any sequencer runs is dropped
    assign accept = start & ~busy;

    //////////////////////////////////////////////////
    // Routing to the sequencers
    //////////////////////////////////////////////////
    always_comb
    begin
        alu_cmd  = '{go: 1'b0, cls: cls, width: width, taken: comparator};
        mem_cmd  = alu_cmd;
        jump_cmd = alu_cmd;

        alu_cmd.go  = accept & legal & (cls == CLS_RTYPE || cls == CLS_ITYPE);
        mem_cmd.go  = accept & legal & (cls == CLS_LOAD || cls == CLS_STORE);
        jump_cmd.go = accept & legal &
                      (cls == CLS_BRANCH || cls == CLS_JAL || cls == CLS_JALR);
    end

    // Illegal pulse lands in cycle 1, like the first sequencer output
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            illegal <= 1'b0;
        else
            illegal <= accept & ~legal;
    end

    // Idle sequencers drive zero, so OR is a merge
    assign ctrl = ctrl_t'(alu_ctrl | mem_ctrl | jump_ctrl);
    assign busy = alu_busy | mem_busy | jump_busy;
    assign done = alu_done | mem_done | jump_done;

    assign any_go = alu_cmd.go | mem_cmd.go | jump_cmd.go;

    a_one_busy: assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_busy, mem_busy, jump_busy}))
        else $error("More than one sequencer busy");

    // Go only from idle, and the chosen sequencer picks it up
    a_go_idle: assert property (@(posedge clk) disable iff (reset)
        any_go |-> !busy ##1 busy)
        else $error("Sequencer go while busy or not taken up");

endmodule

/* source/alu_sequencer.sv */
`timescale 1ns/1ps

module alu_sequencer
    import controller_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  seq_cmd_t cmd,
    output ctrl_t    ctrl,
    output logic     done,
    output logic     busy
);

    typedef enum logic [1:0]
    {
        A_IDLE,
        A_WRITE,
        A_FINISH
    } alu_state_e;

    alu_state_e state;
    logic       is_imm;    // I-type, operand b from immediate

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= A_IDLE;
        else
        begin
            case (state)
                A_IDLE:   if (cmd.go) state <= A_WRITE;
                A_WRITE:  state <= A_FINISH;
                default:  state <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd.go)
            is_imm <= (cmd.cls == CLS_ITYPE);
    end

    assign busy = (state != A_IDLE);
    assign done = (state == A_FINISH);

    always_comb
    begin
        ctrl           = '0;
        ctrl.alu_src   = busy & is_imm;     // Held for the whole sequence
        ctrl.reg_write = (state == A_WRITE);
    end

endmodule

/* source/mem_sequencer.sv */
`timescale 1ns/1ps

module mem_sequencer
    import controller_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  seq_cmd_t cmd,
    output ctrl_t    ctrl,
    output logic     done,
    output logic     busy
);

    typedef enum logic [1:0]
    {
        M_IDLE,
        M_ACCESS,
        M_WRITEBACK,
        M_FINISH
    } mem_state_e;

    mem_state_e state;
    mem_width_e width_q;
    logic       is_load;

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= M_IDLE;
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (cmd.go)
                        state <= M_ACCESS;
                end
                M_ACCESS:
                begin
                    // Stores have nothing to write back
                    if (is_load)
                        state <= M_WRITEBACK;
                    else
                        state <= M_FINISH;
                end
                M_WRITEBACK: state <= M_FINISH;
                default:     state <= M_IDLE;
            endcase
        end
    end

    // Access parameters, captured with go
    always_ff @(posedge clk)
    begin
        if (cmd.go)
        begin
            width_q <= cmd.width;
            is_load <= (cmd.cls == CLS_LOAD);
        end
    end

    assign busy = (state != M_IDLE);
    assign done = (state == M_FINISH);

    //////////////////////////////////////////////////
    // Control word
    //////////////////////////////////////////////////
    always_comb
    begin
        ctrl         = '0;
        ctrl.alu_src = busy;               // Base plus offset address
        if (busy && is_load)
            ctrl.mem_to_reg = WB_MEM;
        if (state == M_ACCESS)
        begin
            ctrl.mem_read  = is_load;
            ctrl.mem_write = ~is_load;
            ctrl.is_byte   = (width_q == W_BYTE);
            ctrl.is_half   = (width_q == W_HALF);
            ctrl.is_word   = (width_q == W_WORD);
        end
        ctrl.reg_write = (state == M_WRITEBACK);
    end

    // Every access carries exactly one width bit
    a_one_width: assert property (@(posedge clk) disable iff (reset)
        (state == M_ACCESS) |-> $onehot({ctrl.is_byte, ctrl.is_half, ctrl.is_word}))
        else $error("Access without exactly one width bit");

endmodule

/* source/jump_sequencer.sv */
`timescale 1ns/1ps

module jump_sequencer
    import controller_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  seq_cmd_t cmd,
    output ctrl_t    ctrl,
    output logic     done,
    output logic     busy
);

    typedef enum logic [1:0]
    {
        J_IDLE,
        J_UPDATE,
        J_FINISH
    } jump_state_e;

    jump_state_e  state;
    instr_class_e cls_q;
    logic         taken_q;
    logic         is_link;   // JAL or JALR, writes PC+4 back

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= J_IDLE;
        else
        begin
            case (state)
                J_IDLE:   if (cmd.go) state <= J_UPDATE;
                J_UPDATE: state <= J_FINISH;
                default:  state <= J_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd.go)
        begin
            cls_q   <= cmd.cls;
            taken_q <= cmd.taken;
        end
    end

    assign busy    = (state != J_IDLE);
    assign done    = (state == J_FINISH);
    assign is_link = (cls_q == CLS_JAL) || (cls_q == CLS_JALR);

    //////////////////////////////////////////////////
    // PC update
    //////////////////////////////////////////////////
    always_comb
    begin
        ctrl = '0;
        if (busy && is_link)
            ctrl.mem_to_reg = WB_PC4;
        if (state == J_UPDATE)
        begin
            case (cls_q)
                CLS_BRANCH:
                begin
                    ctrl.pc_en     = taken_q;  // Untaken falls through to PC+4
                    ctrl.pc_select = taken_q ? PC_BRANCH : PC_PLUS4;
                end
                CLS_JAL:
                begin
                    ctrl.pc_en     = 1'b1;
                    ctrl.pc_select = PC_JAL;
                end
                CLS_JALR:
                begin
                    ctrl.pc_en     = 1'b1;
                    ctrl.pc_select = PC_JALR;
                end
                default: ;
            endcase
            ctrl.reg_write = is_link;
        end
    end

    // Only branch and jump classes may start this sequencer
    a_jump_class: assert property (@(posedge clk) disable iff (reset)
        cmd.go |-> (cmd.cls inside {CLS_BRANCH, CLS_JAL, CLS_JALR}))
        else $error("Jump sequencer started by a non-jump class");

endmodule

/* source/controller.sv */
`timescale 1ns/1ps
`include "controller_defs.svh"

module controller
    import controller_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [`INSTR_W-1:0] instruction,
    input  logic                comparator,
    output ctrl_t               ctrl,
    output logic                busy,
    output logic                done,
    output logic                illegal
);

    // Dispatcher to sequencer commands
    seq_cmd_t alu_cmd;
    seq_cmd_t mem_cmd;
    seq_cmd_t jump_cmd;

    // Sequencer returns
    ctrl_t alu_ctrl;
    ctrl_t mem_ctrl;
    ctrl_t jump_ctrl;
    logic  alu_done;
    logic  mem_done;
    logic  jump_done;
    logic  alu_busy;
    logic  mem_busy;
    logic  jump_busy;

    //////////////////////////////////////////////////
    // Decode and merge
    //////////////////////////////////////////////////
    instr_dispatch u_dispatch
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .instruction (instruction),
        .comparator  (comparator),
        .alu_ctrl    (alu_ctrl),
        .mem_ctrl    (mem_ctrl),
        .jump_ctrl   (jump_ctrl),
        .alu_done    (alu_done),
        .mem_done    (mem_done),
        .jump_done   (jump_done),
        .alu_busy    (alu_busy),
        .mem_busy    (mem_busy),
        .jump_busy   (jump_busy),
        .alu_cmd     (alu_cmd),
        .mem_cmd     (mem_cmd),
        .jump_cmd    (jump_cmd),
        .ctrl        (ctrl),
        .busy        (busy),
        .done        (done),
        .illegal     (illegal)
    );

    //////////////////////////////////////////////////
    // Sequencers
    //////////////////////////////////////////////////
    alu_sequencer u_alu_seq
    (
        .clk   (clk),
        .reset (reset),
        .cmd   (alu_cmd),
        .ctrl  (alu_ctrl),
        .done  (alu_done),
        .busy  (alu_busy)
    );

    mem_sequencer u_mem_seq    // Loads and stores
    (
        .clk   (clk),
        .reset (reset),
        .cmd   (mem_cmd),
        .ctrl  (mem_ctrl),
        .done  (mem_done),
        .busy  (mem_busy)
    );

    jump_sequencer u_jump_seq  // Branch, JAL, JALR
    (
        .clk   (clk),
        .reset (reset),
        .cmd   (jump_cmd),
        .ctrl  (jump_ctrl),
        .done  (jump_done),
        .busy  (jump_busy)
    );

endmodule

/* tests/tb_controller.sv */
`timescale 1ns/1ps
`include "controller_defs.svh"

module tb_controller
    import controller_pkg::*;
();

    logic                clk = 1'b0;
    logic                reset;
    logic                start;
    logic [`INSTR_W-1:0] instruction;
    logic                comparator;
    ctrl_t               ctrl;
    logic                busy;
    logic                done;
    logic                illegal;

    logic [31:0]  seed;
    logic [31:0]  rnd;
    int           errors;
    int           test_base;
    int           tests_run;
    int           tests_failed;
    int           instr_count;

    // Expected decode of the instruction under test
    instr_class_e exp_cls;
    mem_width_e   exp_width;
    logic         exp_legal;
    logic         exp_taken;

    always #10 clk = ~clk;    // 20 ns period

    controller DUT
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .instruction (instruction),
        .comparator  (comparator),
        .ctrl        (ctrl),
        .busy        (busy),
        .done        (done),
        .illegal     (illegal)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic mem_width_e width_of(input logic [2:0] f3);
        if (f3 == `F3_BYTE || f3 == `F3_BYTE_U)
            return W_BYTE;
        else if (f3 == `F3_HALF || f3 == `F3_HALF_U)
            return W_HALF;
        else if (f3 == `F3_WORD)
            return W_WORD;
        return W_NONE;
    endfunction

    // Loads need a write-back cycle
    function automatic int seq_length(input instr_class_e c);
        return (c == CLS_LOAD) ? 3 : 2;
    endfunction

    task automatic decode_instr(input logic [31:0] ins, input logic comp);
        logic [2:0] f3;
        f3        = ins[14:12];
        exp_cls   = CLS_RTYPE;
        exp_width = W_NONE;
        exp_legal = 1'b1;
        exp_taken = comp;
        case (ins[6:0])
            `OP_RTYPE:  exp_cls = CLS_RTYPE;
            `OP_ITYPE:  exp_cls = CLS_ITYPE;
            `OP_BRANCH: exp_cls = CLS_BRANCH;
            `OP_JAL:    exp_cls = CLS_JAL;
            `OP_JALR:   exp_cls = CLS_JALR;
            `OP_LOAD:
            begin
                exp_cls   = CLS_LOAD;
                exp_width = width_of(f3);
                exp_legal = (exp_width != W_NONE);
            end
            `OP_STORE:
            begin
                exp_cls   = CLS_STORE;
                exp_width = width_of(f3);
                exp_legal = (f3 <= `F3_WORD);    // Stores have no unsigned forms
            end
            default: exp_legal = 1'b0;
        endcase
    endtask

    // Control word in cycle cyc after the accepting edge, zero outside the sequence
    function automatic ctrl_t model_ctrl(input instr_class_e c, input mem_width_e w,
                                         input logic t, input int cyc);
        ctrl_t e;
        e = '0;
        if (cyc >= 1 && cyc <= seq_length(c))
        begin
            e.alu_src = (c == CLS_ITYPE || c == CLS_LOAD || c == CLS_STORE);
            if (c == CLS_LOAD)
                e.mem_to_reg = WB_MEM;
            if (c == CLS_JAL || c == CLS_JALR)
                e.mem_to_reg = WB_PC4;
            if (cyc == 1 && (c == CLS_LOAD || c == CLS_STORE))
            begin
                e.mem_read  = (c == CLS_LOAD);
                e.mem_write = (c == CLS_STORE);
                e.is_byte   = (w == W_BYTE);
                e.is_half   = (w == W_HALF);
                e.is_word   = (w == W_WORD);
            end
            e.reg_write = (cyc == 1 && (c == CLS_RTYPE || c == CLS_ITYPE)) ||
                          (cyc == 2 && c == CLS_LOAD) ||
                          (cyc == 1 && (c == CLS_JAL || c == CLS_JALR));
            if (cyc == 1 && (c == CLS_JAL || c == CLS_JALR || (c == CLS_BRANCH && t)))
            begin
                e.pc_en     = 1'b1;
                e.pc_select = (c == CLS_JAL) ? PC_JAL :
                              (c == CLS_JALR) ? PC_JALR : PC_BRANCH;
            end
        end
        return e;
    endfunction

    task automatic compare_outputs(input logic [31:0] ins, input int cyc);
        ctrl_t exp_c;
        logic  exp_b;
        logic  exp_d;
        logic  exp_i;
        int    len;
        len   = seq_length(exp_cls);
        exp_c = model_ctrl(exp_cls, exp_width, exp_taken, exp_legal ? cyc : 0);
        exp_b = exp_legal && cyc >= 1 && cyc <= len;
        exp_d = exp_legal && cyc == len;
        exp_i = !exp_legal && cyc == 1;
        if (ctrl !== exp_c)
        begin
            $display("** Error at %0t: ctrl %h expected %h, cycle %0d of instruction %h",
                     $time, ctrl, exp_c, cyc, ins);
            errors++;
        end
        if (busy !== exp_b)
        begin
            $display("** Error at %0t: busy %b expected %b, cycle %0d of instruction %h",
                     $time, busy, exp_b, cyc, ins);
            errors++;
        end
        if (done !== exp_d)
        begin
            $display("** Error at %0t: done %b expected %b, cycle %0d of instruction %h",
                     $time, done, exp_d, cyc, ins);
            errors++;
        end
        if (illegal !== exp_i)
        begin
            $display("** Error at %0t: illegal %b expected %b, cycle %0d of instruction %h",
                     $time, illegal, exp_i, cyc, ins);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [2:0] f3);
        logic [31:0] r;
        r        = $random(seed);
        r[6:0]   = op;
        r[14:12] = f3;
        return r;
    endfunction

    // Mostly legal opcodes, func3 left random
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] sel;
        r   = $random(seed);
        sel = $random(seed);
        case (sel[3:0])
            4'd0, 4'd1:   r[6:0] = `OP_RTYPE;
            4'd2, 4'd3:   r[6:0] = `OP_ITYPE;
            4'd4, 4'd5:   r[6:0] = `OP_LOAD;
            4'd6, 4'd7:   r[6:0] = `OP_STORE;
            4'd8, 4'd9:   r[6:0] = `OP_BRANCH;
            4'd10, 4'd11: r[6:0] = `OP_JAL;
            4'd12, 4'd13: r[6:0] = `OP_JALR;
            default: ;    // Raw opcode
        endcase
        return r;
    endfunction

    // One instruction from idle back to idle; hold keeps start high while busy
    task automatic run_instr(input logic [31:0] ins, input logic comp, input logic hold);
        logic [31:0] other;
        logic        keep;
        logic        ended;
        int          cyc;
        decode_instr(ins, comp);
        keep = hold & exp_legal;    // An illegal one never makes the unit busy
        instr_count++;
        cyc = 0;
        while (busy && cyc < 8)
        begin
            @(negedge clk);
            cyc++;
        end
        if (busy)
        begin
            $display("Timeout: DUT still busy before instruction %h was issued", ins);
            errors++;
        end
        @(posedge clk);
        start       <= 1'b1;
        instruction <= ins;
        comparator  <= comp;
        @(posedge clk);                 // Accepting edge
        other = $random(seed);
        if (keep)
            instruction <= other;
        else
            start <= 1'b0;
        comparator <= ~comp;            // Taken was latched at the accepting edge
        cyc   = 0;
        ended = 1'b0;
        while (!ended && cyc < 8)
        begin
            @(negedge clk);
            cyc++;
            compare_outputs(ins, cyc);
            ended = exp_legal ? done : illegal;
        end
        if (!ended)
        begin
            $display("Timeout: instruction %h did not finish within %0d cycles", ins, cyc);
            errors++;
        end
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        compare_outputs(ins, 0);        // Idle again
    endtask

    task automatic start_test();
        test_base = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_base)
            tests_failed++;
        $display("Test %-20s %-6s %0d errors", name,
                 (errors == test_base) ? "ok" : "FAILED", errors - test_base);
    endtask

    initial
    begin
        seed         = 32'hf692;
        errors       = 0;
        test_base    = 0;
        tests_run    = 0;
        tests_failed = 0;
        instr_count  = 0;
        reset        = 1'b1;
        start        = 1'b0;
        instruction  = '0;
        comparator   = 1'b0;
        exp_cls      = CLS_RTYPE;
        exp_width    = W_NONE;
        exp_legal    = 1'b1;
        exp_taken    = 1'b0;

        start_test();
        repeat (9) @(posedge clk);
        @(negedge clk);
        compare_outputs('0, 0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_outputs('0, 0);
        finish_test("reset");

        start_test();
        for (int f3 = 0; f3 < 8; f3++)
        begin
            rnd = $random(seed);
            run_instr(make_instr(`OP_RTYPE, f3[2:0]), rnd[0], 1'b0);
            run_instr(make_instr(`OP_ITYPE, f3[2:0]), rnd[1], 1'b0);
        end
        finish_test("R-type and I-type");

        start_test();
        for (int f3 = 0; f3 < 6; f3++)
            if (f3 != 3)
                run_instr(make_instr(`OP_LOAD, f3[2:0]), 1'b0, 1'b0);
        finish_test("load");

        start_test();
        for (int f3 = 0; f3 < 3; f3++)
            run_instr(make_instr(`OP_STORE, f3[2:0]), 1'b1, 1'b0);
        finish_test("store");

        start_test();
        for (int i = 0; i < 16; i++)
            run_instr(make_instr(`OP_BRANCH, 3'd0), i[0], 1'b0);
        finish_test("branch");

        start_test();
        for (int i = 0; i < 8; i++)
            run_instr(make_instr(i[0] ? `OP_JALR : `OP_JAL, 3'd0), i[1], 1'b0);
        finish_test("JAL and JALR");

        start_test();
        for (int i = 0; i < 12; i++)
        begin
            rnd      = $random(seed);
            rnd[1:0] = 2'b00;               // No 32-bit opcode ends in 00
            run_instr(rnd, rnd[31], 1'b0);
        end
        for (int f3 = 3; f3 < 8; f3++)
        begin
            if (f3 != 4 && f3 != 5)
                run_instr(make_instr(`OP_LOAD, f3[2:0]), 1'b0, 1'b0);
            run_instr(make_instr(`OP_STORE, f3[2:0]), 1'b0, 1'b0);
        end
        finish_test("illegal");

        start_test();
        for (int i = 0; i < 12; i++)
        begin
            rnd = $random(seed);
            run_instr(random_instr(), rnd[0], 1'b1);
        end
        finish_test("start while busy");

        start_test();
        for (int i = 0; i < 200; i++)
        begin
            rnd = $random(seed);
            run_instr(random_instr(), rnd[0], rnd[1]);
        end
        finish_test("random");

        // Reset in the middle of a load
        start_test();
        exp_legal = 1'b1;
        @(posedge clk);
        start       <= 1'b1;
        instruction <= make_instr(`OP_LOAD, `F3_WORD);
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        compare_outputs('0, 0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_outputs('0, 0);
        finish_test("reset mid-sequence");

        $display("Summary: %0d tests, %0d failing, %0d instructions, %0d errors",
                 tests_run, tests_failed, instr_count, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
source/controller_pkg.sv
source/instr_dispatch.sv
source/alu_sequencer.sv
source/mem_sequencer.sv
source/jump_sequencer.sv
source/controller.sv
tests/tb_controller.sv

/* run.sh */
#!/bin/bash
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_controller \
    -o sim_controller

output=$(./obj_dir/sim_controller)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
